// ==== source/mips_ctrl_consts.svh ====
`ifndef MIPS_CTRL_CONSTS_SVH
`define MIPS_CTRL_CONSTS_SVH

// Primary opcode field, instr[31:26]
`define OPCODE_W 6

// R-type function field, instr[5:0]
`define FUNCT_W 6

// ALU operation select toward the datapath
`define ALU_CTRL_W 4

// Select for the four-input srcB mux
`define SRCB_SEL_W 2

// Sequencer state encoding, 15 states used
`define STATE_W 4

`endif

// ==== source/isa_pkg.sv ====
`include "mips_ctrl_consts.svh"

package isa_pkg;

    // Supported primary opcodes
    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // Supported R-type funct codes
    typedef enum logic [`FUNCT_W-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2A
    } funct_t;

    // Instruction class, picks the path after decode
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_UNDEF
    } instr_class_t;

    // ALU operation codes as the datapath ALU expects them
    typedef enum logic [`ALU_CTRL_W-1:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_NOR = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_t;

    // srcB mux inputs: register B, constant 4, imm, imm shifted by 2
    typedef enum logic [`SRCB_SEL_W-1:0] {
        SRCB_REG       = 2'd0,
        SRCB_FOUR      = 2'd1,
        SRCB_IMM       = 2'd2,
        SRCB_IMM_SHIFT = 2'd3
    } srcb_sel_t;

endpackage

// ==== source/ctrl_pkg.sv ====
`include "mips_ctrl_consts.svh"

package ctrl_pkg;

    // Multicycle sequencer states
    // Every state lasts exactly one clock
    typedef enum logic [`STATE_W-1:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_WRITEBACK,
        // Memory path, shared address step
        S_MEM_ADDR,
        S_STORE,
        S_STORE_HOLD,
        S_LOAD,
        // Branch path, target first, compare second
        S_BR_ADDR,
        S_BEQ_CMP,
        S_BNE_CMP,
        // Jump path
        S_JUMP,
        S_UPDATE_PC,
        // Quiet state for unsupported instructions
        S_UNDEF
    } ctrl_state_t;

endpackage

// ==== source/decode_if.sv ====
// Decoded fields of the instruction held in the IR
interface decode_if
    import isa_pkg::*;
();

    // Path taken after the decode state
    instr_class_t instr_class;

    // ALU operation for the execute and address steps
    alu_op_t      alu_control;

    // srcB operand for the instruction's own ALU step
    srcb_sel_t    alu_src_b;

    // Destination register select, 1 picks rd, 0 picks rt
    logic         reg_dst;

    // Decoder side
    modport producer (output instr_class, alu_control, alu_src_b, reg_dst);

    // Sequencer and encoder side
    modport consumer (input instr_class, alu_control, alu_src_b, reg_dst);

endinterface

// ==== source/instr_decoder.sv ====
module instr_decoder
    import isa_pkg::*;
(
    input  opcode_t           opcode,
    input  funct_t            funct,
    decode_if.producer        dec
);

    always_comb
    begin
        // Anything not matched below stays undefined
        dec.instr_class = CLS_UNDEF;
        dec.alu_control = ALU_ADD;
        dec.alu_src_b   = SRCB_IMM;
        dec.reg_dst     = 1'b0;

        case (opcode)
            OP_RTYPE:
            begin
                // Both operands from the register file, result to rd
                dec.alu_src_b   = SRCB_REG;
                dec.reg_dst     = 1'b1;
                dec.instr_class = CLS_ALU;
                case (funct)
                    FN_ADD: dec.alu_control = ALU_ADD;
                    FN_SUB: dec.alu_control = ALU_SUB;
                    FN_AND: dec.alu_control = ALU_AND;
                    FN_OR:  dec.alu_control = ALU_OR;
                    FN_NOR: dec.alu_control = ALU_NOR;
                    FN_SLT: dec.alu_control = ALU_SLT;
                    // Unknown funct, no register write may follow
                    default: dec.instr_class = CLS_UNDEF;
                endcase
            end
            // Immediate ALU group, result to rt
            OP_ADDI:
            begin
                dec.instr_class = CLS_ALU;
                dec.alu_control = ALU_ADD;
            end
            OP_ANDI:
            begin
                dec.instr_class = CLS_ALU;
                dec.alu_control = ALU_AND;
            end
            OP_ORI:
            begin
                dec.instr_class = CLS_ALU;
                dec.alu_control = ALU_OR;
            end
            OP_LUI:
            begin
                dec.instr_class = CLS_ALU;
                dec.alu_control = ALU_LUI;
            end
            // Memory access, base plus offset
            OP_LW:
            begin
                dec.instr_class = CLS_LOAD;
            end
            OP_SW:
            begin
                dec.instr_class = CLS_STORE;
            end
            // Branches compare rs and rt by subtraction
            OP_BEQ, OP_BNE:
            begin
                dec.instr_class = CLS_BRANCH;
                dec.alu_control = ALU_SUB;
                dec.alu_src_b   = SRCB_REG;
            end
            OP_J:
            begin
                dec.instr_class = CLS_JUMP;
            end
            default:
            begin
                dec.instr_class = CLS_UNDEF;
            end
        endcase
    end

    // A clean opcode from the IR must always give a clean class
    always_comb
    begin
        if (!$isunknown(opcode))
        begin
            class_known: assert final (!$isunknown(dec.instr_class));
        end
    end

endmodule

// ==== source/state_sequencer.sv ====
module state_sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  opcode_t           opcode,
    decode_if.consumer        dec,
    output ctrl_state_t       state
);

    ctrl_state_t state_next;

    // State register
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Next-state rules, one clock per state
    always_comb
    begin
        state_next = S_IDLE;
        case (state)
            S_IDLE:      state_next = S_FETCH;
            S_FETCH:     state_next = S_DECODE;
            S_DECODE:
            begin
                // IR is loaded by now, the class picks the path
                case (dec.instr_class)
                    CLS_ALU:    state_next = S_EXECUTE;
                    CLS_LOAD,
                    CLS_STORE:  state_next = S_MEM_ADDR;
                    CLS_BRANCH: state_next = S_BR_ADDR;
                    CLS_JUMP:   state_next = S_JUMP;
                    default:    state_next = S_UNDEF;
                endcase
            end
            S_EXECUTE:   state_next = S_WRITEBACK;
            S_MEM_ADDR:
            begin
                // Address is ready, split on direction
                if (dec.instr_class == CLS_STORE)
                begin
                    state_next = S_STORE;
                end
                else
                begin
                    state_next = S_LOAD;
                end
            end
            S_STORE:     state_next = S_STORE_HOLD;
            S_BR_ADDR:
            begin
                // Target computed, the opcode tells the compare sense
                case (opcode)
                    OP_BEQ:  state_next = S_BEQ_CMP;
                    OP_BNE:  state_next = S_BNE_CMP;
                    default: state_next = S_UNDEF;
                endcase
            end
            S_JUMP:      state_next = S_UPDATE_PC;
            // Last step of each instruction
            S_WRITEBACK,
            S_STORE_HOLD,
            S_LOAD,
            S_BEQ_CMP,
            S_BNE_CMP,
            S_UPDATE_PC,
            S_UNDEF:     state_next = S_FETCH;
            default:     state_next = S_IDLE;
        endcase
    end

    // Register never holds the unused encoding or X
    state_defined: assert property (
        @(posedge clk) disable iff (!reset)
        !$isunknown(state) &&
        (state inside {S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_WRITEBACK,
                       S_MEM_ADDR, S_STORE, S_STORE_HOLD, S_LOAD,
                       S_BR_ADDR, S_BEQ_CMP, S_BNE_CMP,
                       S_JUMP, S_UPDATE_PC, S_UNDEF})
    );

endmodule

// ==== source/control_encoder.sv ====
module control_encoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  ctrl_state_t       state,
    input  logic              zero,
    decode_if.consumer        dec,
    output logic              iord,
    output logic              mem_write,
    output logic              ir_write,
    output logic              reg_dst,
    output logic              mem_to_reg,
    output logic              pc_write,
    output logic              branch,
    output logic              pc_src,
    output alu_op_t           alu_control,
    output srcb_sel_t         alu_src_b,
    output logic              alu_src_a,
    output logic              reg_write,
    output logic              mem_select,
    output logic              data_write,
    output logic              rd_ff_en,
    output logic              alu_result_en,
    output logic              pc_en,
    output logic              jump
);

    always_comb
    begin
        // All strobes low unless the state asks for them
        iord          = 1'b0;
        mem_write     = 1'b0;
        ir_write      = 1'b0;
        reg_dst       = 1'b0;
        mem_to_reg    = 1'b0;
        pc_write      = 1'b0;
        branch        = 1'b0;
        pc_src        = 1'b0;
        alu_control   = ALU_AND;
        alu_src_b     = SRCB_REG;
        alu_src_a     = 1'b0;
        reg_write     = 1'b0;
        mem_select    = 1'b0;
        data_write    = 1'b0;
        rd_ff_en      = 1'b0;
        alu_result_en = 1'b0;
        jump          = 1'b0;

        case (state)
            S_FETCH, S_UPDATE_PC:
            begin
                // Load IR from ROM and step PC by 4
                ir_write    = 1'b1;
                pc_write    = 1'b1;
                alu_src_b   = SRCB_FOUR;
                alu_control = ALU_ADD;
                // Jump target still selected while the next fetch starts
                jump        = (state == S_UPDATE_PC);
            end
            S_DECODE:
            begin
                // Latch RD1 and RD2 for the next step
                rd_ff_en    = 1'b1;
                alu_src_a   = 1'b1;
                reg_dst     = dec.reg_dst;
                alu_control = dec.alu_control;
                alu_src_b   = dec.alu_src_b;
            end
            S_EXECUTE:
            begin
                alu_src_a     = 1'b1;
                alu_result_en = 1'b1;
                reg_dst       = dec.reg_dst;
                alu_control   = dec.alu_control;
                alu_src_b     = dec.alu_src_b;
            end
            S_WRITEBACK:
            begin
                // ALUOut into rd or rt
                reg_write     = 1'b1;
                alu_result_en = 1'b1;
                reg_dst       = dec.reg_dst;
                alu_control   = dec.alu_control;
            end
            S_MEM_ADDR:
            begin
                // Base register plus sign-extended offset
                rd_ff_en      = 1'b1;
                alu_src_a     = 1'b1;
                alu_result_en = 1'b1;
                alu_src_b     = SRCB_IMM;
                alu_control   = dec.alu_control;
            end
            S_STORE:
            begin
                iord       = 1'b1;
                mem_write  = 1'b1;
                mem_select = 1'b1;
            end
            // Address held one more cycle after the RAM write
            S_STORE_HOLD: iord = 1'b1;
            S_LOAD:
            begin
                // RAM data straight into the register file
                iord       = 1'b1;
                mem_select = 1'b1;
                data_write = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                reg_dst    = dec.reg_dst;
            end
            S_BR_ADDR:
            begin
                // PC plus shifted offset into ALUOut
                alu_result_en = 1'b1;
                alu_src_b     = SRCB_IMM_SHIFT;
                alu_control   = ALU_ADD;
            end
            S_BEQ_CMP, S_BNE_CMP:
            begin
                // rs minus rt, zero flag decides the PC update
                rd_ff_en    = 1'b1;
                alu_src_a   = 1'b1;
                pc_src      = 1'b1;
                alu_control = ALU_SUB;
                branch      = (state == S_BEQ_CMP) ? zero : !zero;
            end
            S_JUMP: jump = 1'b1;
            default:
            begin
                // Idle and quiet states keep everything low
            end
        endcase
    end

    // PC register enable
    assign pc_en = branch | pc_write;

    // RAM write and register write never share a cycle
    always_comb
    begin
        no_mem_and_reg_write: assert final (!(mem_write && reg_write));
    end

endmodule

// ==== source/mips_ctrl.sv ====
`include "mips_ctrl_consts.svh"

module mips_ctrl
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`OPCODE_W-1:0]     opcode,
    input  logic [`FUNCT_W-1:0]      funct,
    input  logic                     zero,
    output logic                     iord,
    output logic                     mem_write,
    output logic                     ir_write,
    output logic                     reg_dst,
    output logic                     mem_to_reg,
    output logic                     pc_write,
    output logic                     branch,
    output logic                     pc_src,
    output logic [`ALU_CTRL_W-1:0]   alu_control,
    output logic [`SRCB_SEL_W-1:0]   alu_src_b,
    output logic                     alu_src_a,
    output logic                     reg_write,
    output logic                     mem_select,
    output logic                     data_write,
    output logic                     rd_ff_en,
    output logic                     alu_result_en,
    output logic                     pc_en,
    output logic                     jump
);

    ctrl_state_t state;

    // Decoded IR fields shared by sequencer and encoder
    decode_if dec_bus ();

    instr_decoder instr_decoder_i (
        .opcode (opcode_t'(opcode)),
        .funct  (funct_t'(funct)),
        .dec    (dec_bus.producer)
    );

    state_sequencer state_sequencer_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode_t'(opcode)),
        .dec    (dec_bus.consumer),
        .state  (state)
    );

    control_encoder control_encoder_i (
        .state         (state),
        .zero          (zero),
        .dec           (dec_bus.consumer),
        .iord          (iord),
        .mem_write     (mem_write),
        .ir_write      (ir_write),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_write      (pc_write),
        .branch        (branch),
        .pc_src        (pc_src),
        .alu_control   (alu_control),
        .alu_src_b     (alu_src_b),
        .alu_src_a     (alu_src_a),
        .reg_write     (reg_write),
        .mem_select    (mem_select),
        .data_write    (data_write),
        .rd_ff_en      (rd_ff_en),
        .alu_result_en (alu_result_en),
        .pc_en         (pc_en),
        .jump          (jump)
    );

endmodule

// ==== bench/mips_ctrl_tb.sv ====
`include "mips_ctrl_consts.svh"

module mips_ctrl_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int MAX_ROWS = 64;
    localparam int MAX_INSTR_CYCLES = 8;

    logic                    clk;
    logic                    reset;
    logic [`OPCODE_W-1:0]    opcode;
    logic [`FUNCT_W-1:0]     funct;
    logic                    zero;
    logic                    iord;
    logic                    mem_write;
    logic                    ir_write;
    logic                    reg_dst;
    logic                    mem_to_reg;
    logic                    pc_write;
    logic                    branch;
    logic                    pc_src;
    logic [`ALU_CTRL_W-1:0]  alu_control;
    logic [`SRCB_SEL_W-1:0]  alu_src_b;
    logic                    alu_src_a;
    logic                    reg_write;
    logic                    mem_select;
    logic                    data_write;
    logic                    rd_ff_en;
    logic                    alu_result_en;
    logic                    pc_en;
    logic                    jump;
    logic [21:0]             all_outputs;

    // Golden rows with stimulus first and expected results after
    logic [`OPCODE_W-1:0]    row_opcode [MAX_ROWS];
    logic [`FUNCT_W-1:0]     row_funct [MAX_ROWS];
    logic                    row_zero [MAX_ROWS];
    int                      row_cycles [MAX_ROWS];
    logic [`ALU_CTRL_W-1:0]  row_alu [MAX_ROWS];
    int                      row_reg_writes [MAX_ROWS];
    int                      row_mem_writes [MAX_ROWS];
    int                      row_pc_en [MAX_ROWS];
    logic                    row_reg_dst [MAX_ROWS];
    int                      num_rows;
    logic                    rows_loaded;
    int                      mismatches;
    int                      failures;

    mips_ctrl mips_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .iord          (iord),
        .mem_write     (mem_write),
        .ir_write      (ir_write),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_write      (pc_write),
        .branch        (branch),
        .pc_src        (pc_src),
        .alu_control   (alu_control),
        .alu_src_b     (alu_src_b),
        .alu_src_a     (alu_src_a),
        .reg_write     (reg_write),
        .mem_select    (mem_select),
        .data_write    (data_write),
        .rd_ff_en      (rd_ff_en),
        .alu_result_en (alu_result_en),
        .pc_en         (pc_en),
        .jump          (jump)
    );

    // Every control output packed into one vector for the quiet checks
    assign all_outputs = {iord, mem_write, ir_write, reg_dst, mem_to_reg, pc_write, branch,
                          pc_src, alu_control, alu_src_b, alu_src_a, reg_write, mem_select,
                          data_write, rd_ff_en, alu_result_en, pc_en, jump};

    always #50 clk = ~clk;

    // Comment and blank lines fail the scan and are skipped
    task automatic load_golden_rows();
        int fd;
        int n;
        int code;
        string line;
        logic [31:0] f_op;
        logic [31:0] f_fn;
        logic [31:0] f_zero;
        logic [31:0] f_alu;
        logic [31:0] f_rdst;
        int f_cyc;
        int f_rw;
        int f_mw;
        int f_pc;
        fd = $fopen("bench/mips_ctrl_golden.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the golden file bench/mips_ctrl_golden.txt");
            failures++;
        end
        else
        begin
            while (!$feof(fd) && num_rows < MAX_ROWS)
            begin
                line = "";
                code = 0;
                n = $fgets(line, fd);
                if (n > 0)
                begin
                    code = $sscanf(line, "%h %h %h %d %h %d %d %d %h", f_op, f_fn, f_zero,
                                   f_cyc, f_alu, f_rw, f_mw, f_pc, f_rdst);
                end
                if (code == 9)
                begin
                    row_opcode[num_rows]     = f_op[`OPCODE_W-1:0];
                    row_funct[num_rows]      = f_fn[`FUNCT_W-1:0];
                    row_zero[num_rows]       = f_zero[0];
                    row_cycles[num_rows]     = f_cyc;
                    row_alu[num_rows]        = f_alu[`ALU_CTRL_W-1:0];
                    row_reg_writes[num_rows] = f_rw;
                    row_mem_writes[num_rows] = f_mw;
                    row_pc_en[num_rows]      = f_pc;
                    row_reg_dst[num_rows]    = f_rdst[0];
                    num_rows++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Reset held for 5 rising edges
    // Outputs stay quiet until the first fetch
    task automatic check_until_first_fetch();
        int waited;
        logic fetch_seen;
        waited = 0;
        fetch_seen = 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            if (all_outputs !== 22'd0)
            begin
                $display("mismatch outputs in reset: got %h, expected %h", all_outputs, 22'd0);
                mismatches++;
            end
        end
        @(posedge clk);
        #10;
        reset = 1'b1;
        while (!fetch_seen && waited < 4)
        begin
            @(negedge clk);
            waited++;
            if (ir_write)
            begin
                fetch_seen = 1'b1;
            end
            else if (all_outputs !== 22'd0)
            begin
                $display("mismatch outputs before fetch: got %h, expected %h", all_outputs,
                         22'd0);
                mismatches++;
            end
        end
        if (!fetch_seen)
        begin
            $display("no fetch seen within 4 cycles after reset release");
            failures++;
        end
        if (pc_en !== 1'b1)
        begin
            $display("mismatch pc_en in first fetch: got %h, expected %h", pc_en, 1'b1);
            mismatches++;
        end
    endtask

    // Runs from the sample of one fetch to the sample of the next
    task automatic run_row(input int r);
        int cycles;
        int reg_write_cnt;
        int mem_write_cnt;
        int pc_en_cnt;
        int jump_cnt;
        int jump_exp;
        logic [`ALU_CTRL_W-1:0] alu_seen;
        logic reg_dst_seen;
        logic fetch_seen;
        cycles = 1;
        reg_write_cnt = reg_write ? 1 : 0;
        mem_write_cnt = mem_write ? 1 : 0;
        pc_en_cnt = pc_en ? 1 : 0;
        jump_cnt = jump ? 1 : 0;
        alu_seen = '0;
        reg_dst_seen = 1'b0;
        fetch_seen = 1'b0;
        // IR loads at the end of fetch so the new fields follow that edge
        @(posedge clk);
        #10;
        opcode = row_opcode[r];
        funct = row_funct[r];
        zero = row_zero[r];
        while (!fetch_seen && cycles <= MAX_INSTR_CYCLES)
        begin
            @(negedge clk);
            // UPDATE_PC also raises ir_write but together with jump
            if (ir_write && !jump)
            begin
                fetch_seen = 1'b1;
            end
            else
            begin
                cycles++;
                // Step right after decode
                if (cycles == 3)
                begin
                    alu_seen = alu_control;
                end
                if (reg_write)
                begin
                    reg_write_cnt++;
                    reg_dst_seen = reg_dst;
                end
                if (mem_write)
                begin
                    mem_write_cnt++;
                end
                if (pc_en)
                begin
                    pc_en_cnt++;
                end
                if (jump)
                begin
                    jump_cnt++;
                end
            end
        end
        if (!fetch_seen)
        begin
            $display("row %0d did not return to fetch within %0d cycles", r, MAX_INSTR_CYCLES);
            failures++;
        end
        if (cycles != row_cycles[r])
        begin
            $display("mismatch row %0d cycles: got %h, expected %h", r, cycles, row_cycles[r]);
            mismatches++;
        end
        if (alu_seen !== row_alu[r])
        begin
            $display("mismatch row %0d alu_control: got %h, expected %h", r, alu_seen, row_alu[r]);
            mismatches++;
        end
        if (reg_write_cnt != row_reg_writes[r])
        begin
            $display("mismatch row %0d reg_write count: got %h, expected %h", r, reg_write_cnt,
                     row_reg_writes[r]);
            mismatches++;
        end
        if (mem_write_cnt != row_mem_writes[r])
        begin
            $display("mismatch row %0d mem_write count: got %h, expected %h", r, mem_write_cnt,
                     row_mem_writes[r]);
            mismatches++;
        end
        if (pc_en_cnt != row_pc_en[r])
        begin
            $display("mismatch row %0d pc_en count: got %h, expected %h", r, pc_en_cnt,
                     row_pc_en[r]);
            mismatches++;
        end
        if (reg_dst_seen !== row_reg_dst[r])
        begin
            $display("mismatch row %0d reg_dst: got %h, expected %h", r, reg_dst_seen,
                     row_reg_dst[r]);
            mismatches++;
        end
        // Jump target select stays up through JUMP and UPDATE_PC
        jump_exp = (row_opcode[r] == OP_J) ? 2 : 0;
        if (jump_cnt != jump_exp)
        begin
            $display("mismatch row %0d jump count: got %h, expected %h", r, jump_cnt, jump_exp);
            mismatches++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b0;
        opcode = '0;
        funct = '0;
        zero = 1'b0;
        num_rows = 0;
        rows_loaded = 1'b0;
        mismatches = 0;
        failures = 0;
        load_golden_rows();
        rows_loaded = 1'b1;
        if (num_rows == 0)
        begin
            $display("golden file holds no instruction rows");
            failures++;
        end
        check_until_first_fetch();
        for (int r = 0; r < num_rows; r++)
        begin
            run_row(r);
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Watchdog sized at 6 cycles per row plus reset and margin
    initial
    begin
        wait (rows_loaded);
        #((num_rows * 6 + 10) * 100);
        $display("timeout after %0d cycles, the run did not complete", num_rows * 6 + 10);
        $display("mismatches: %0d, other errors: %0d", mismatches, failures + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== bench/mips_ctrl_golden.txt ====
# opcode funct zero (hex) | cycles alu_control (hex) reg_writes mem_writes pc_en_cycles
# | reg_dst at writeback or load (hex)
00 20 0  4 2  1 0 1  1
00 22 0  4 1  1 0 1  1
00 24 0  4 0  1 0 1  1
00 25 1  4 3  1 0 1  1
00 27 0  4 5  1 0 1  1
00 2a 0  4 4  1 0 1  1
08 15 0  4 2  1 0 1  0
0c 00 0  4 0  1 0 1  0
0d 3f 0  4 3  1 0 1  0
0f 00 0  4 6  1 0 1  0
23 00 0  4 2  1 0 1  0
2b 00 0  5 2  0 1 1  0
04 00 1  4 2  0 0 2  0
04 00 0  4 2  0 0 1  0
05 00 0  4 2  0 0 2  0
05 00 1  4 2  0 0 1  0
02 00 0  4 0  0 0 2  0
2b 20 1  5 2  0 1 1  0
3f 00 0  3 0  0 0 1  0
00 3f 0  3 0  0 0 1  0
00 20 0  4 2  1 0 1  1

// ==== mips_ctrl.f ====
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/decode_if.sv
source/instr_decoder.sv
source/state_sequencer.sv
source/control_encoder.sv
source/mips_ctrl.sv
bench/mips_ctrl_tb.sv

// ==== Makefile ====
# Verilator flow for the multicycle control unit

all: run

obj_dir/Vmips_ctrl_tb: mips_ctrl.f source/*.sv source/*.svh bench/*.sv
	verilator --binary --timing -f mips_ctrl.f --top-module mips_ctrl_tb -Mdir obj_dir

# Pass only when the simulation prints the pass line
run: obj_dir/Vmips_ctrl_tb
	@out="$$(./obj_dir/Vmips_ctrl_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing -f mips_ctrl.f --top-module mips_ctrl

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
